// ==== compile.f ====
+incdir+include
hw/lc4_pkg.sv
hw/lc4_fetch.sv
hw/lc4_decoder.sv
hw/lc4_regfile.sv
hw/lc4_decode_stage.sv
hw/lc4_alu.sv
hw/lc4_execute.sv
hw/lc4_core.sv
verification/tb_lc4_core.sv

// ==== hw/lc4_alu.sv ====
// LC4 ALU
// Result of each kept operation, including branch and jump targets
module lc4_alu (
   input  lc4_pkg::insn_t             i_insn,
   input  logic [lc4_pkg::WORD_W-1:0] i_pc,
   input  lc4_pkg::alu_op_t           i_alu_op,
   input  logic [lc4_pkg::WORD_W-1:0] i_rs_data,
   input  logic [lc4_pkg::WORD_W-1:0] i_rt_data,
   output logic [lc4_pkg::WORD_W-1:0] o_result
);

   logic [4:0]                 imm5;
   logic [10:0]                imm11;
   logic [lc4_pkg::WORD_W-1:0] sext5, sext9, sext11;
   logic [lc4_pkg::WORD_W-1:0] pc_plus_one;

   // imm5 sits in the low subop bits and rt, imm11 spans rd_nzp and imm9
   assign imm5  = {i_insn.reg_form.subop[1:0], i_insn.reg_form.rt};
   assign imm11 = {i_insn.imm_form.rd_nzp[1:0], i_insn.imm_form.imm9};

   assign sext5       = {{11{imm5[4]}}, imm5};
   assign sext9       = {{7{i_insn.imm_form.imm9[8]}}, i_insn.imm_form.imm9};
   assign sext11      = {{5{imm11[10]}}, imm11};
   assign pc_plus_one = i_pc + 16'd1;

   always_comb begin
      case (i_alu_op)
         lc4_pkg::ALU_ADD:     o_result = i_rs_data + i_rt_data;
         lc4_pkg::ALU_MUL:     o_result = i_rs_data * i_rt_data;
         lc4_pkg::ALU_SUB:     o_result = i_rs_data - i_rt_data;
         lc4_pkg::ALU_AND:     o_result = i_rs_data & i_rt_data;
         lc4_pkg::ALU_NOT:     o_result = ~i_rs_data;
         lc4_pkg::ALU_OR:      o_result = i_rs_data | i_rt_data;
         lc4_pkg::ALU_XOR:     o_result = i_rs_data ^ i_rt_data;
         lc4_pkg::ALU_ADDI:    o_result = i_rs_data + sext5;
         lc4_pkg::ALU_ANDI:    o_result = i_rs_data & sext5;
         lc4_pkg::ALU_CONST:   o_result = sext9;
         lc4_pkg::ALU_HICONST: o_result = {i_insn.imm_form.imm9[7:0], i_rs_data[7:0]};
         lc4_pkg::ALU_BR_TGT:  o_result = pc_plus_one + sext9;
         lc4_pkg::ALU_JMP_TGT: o_result = pc_plus_one + sext11;
         default:              o_result = i_rs_data;
      endcase
   end

endmodule

// ==== hw/lc4_core.sv ====
// LC4 pipelined core
// Fetch, decode and execute stages joined with the redirect and writeback paths
module lc4_core (
   input  logic                          gwe,
   input  logic                          i_rst_n,
   input  logic [lc4_pkg::WORD_W-1:0]    i_cur_insn,
   output logic [lc4_pkg::WORD_W-1:0]    o_cur_pc,
   output logic                          o_wb_valid,
   output logic [lc4_pkg::WORD_W-1:0]    o_wb_pc,
   output logic [lc4_pkg::WORD_W-1:0]    o_wb_insn,
   output logic                          o_wb_regfile_we,
   output logic [lc4_pkg::REG_SEL_W-1:0] o_wb_wsel,
   output logic [lc4_pkg::WORD_W-1:0]    o_wb_wdata,
   output logic                          o_wb_nzp_we,
   output logic [lc4_pkg::NZP_W-1:0]     o_wb_nzp
);

   logic [lc4_pkg::WORD_W-1:0]    fd_insn, fd_pc, redirect_pc;
   logic                          fd_valid, redirect;
   logic [lc4_pkg::WORD_W-1:0]    dx_insn, dx_pc, dx_rs_data, dx_rt_data;
   logic [lc4_pkg::REG_SEL_W-1:0] dx_rs_sel, dx_rt_sel, dx_wsel;
   logic                          dx_valid, dx_regfile_we, dx_nzp_we, dx_is_branch, dx_is_jump;
   lc4_pkg::alu_op_t              dx_alu_op;

   lc4_fetch u_fetch (
      .gwe(gwe), .i_rst_n(i_rst_n), .i_cur_insn(i_cur_insn),
      .i_redirect(redirect), .i_redirect_pc(redirect_pc), .o_cur_pc(o_cur_pc),
      .o_fd_insn(fd_insn), .o_fd_pc(fd_pc), .o_fd_valid(fd_valid)
   );

   lc4_decode_stage u_decode (
      .gwe(gwe), .i_rst_n(i_rst_n), .i_fd_insn(fd_insn), .i_fd_pc(fd_pc),
      .i_fd_valid(fd_valid), .i_flush(redirect), .i_wb_regfile_we(o_wb_regfile_we),
      .i_wb_wsel(o_wb_wsel), .i_wb_wdata(o_wb_wdata),
      .o_dx_insn(dx_insn), .o_dx_pc(dx_pc), .o_dx_valid(dx_valid),
      .o_dx_rs_data(dx_rs_data), .o_dx_rt_data(dx_rt_data),
      .o_dx_rs_sel(dx_rs_sel), .o_dx_rt_sel(dx_rt_sel), .o_dx_wsel(dx_wsel),
      .o_dx_regfile_we(dx_regfile_we), .o_dx_nzp_we(dx_nzp_we),
      .o_dx_is_branch(dx_is_branch), .o_dx_is_jump(dx_is_jump), .o_dx_alu_op(dx_alu_op)
   );

   lc4_execute u_execute (
      .gwe(gwe), .i_rst_n(i_rst_n), .i_dx_insn(dx_insn), .i_dx_pc(dx_pc),
      .i_dx_valid(dx_valid), .i_dx_rs_data(dx_rs_data), .i_dx_rt_data(dx_rt_data),
      .i_dx_rs_sel(dx_rs_sel), .i_dx_rt_sel(dx_rt_sel), .i_dx_wsel(dx_wsel),
      .i_dx_regfile_we(dx_regfile_we), .i_dx_nzp_we(dx_nzp_we),
      .i_dx_is_branch(dx_is_branch), .i_dx_is_jump(dx_is_jump), .i_dx_alu_op(dx_alu_op),
      .o_redirect(redirect), .o_redirect_pc(redirect_pc),
      .o_wb_valid(o_wb_valid), .o_wb_pc(o_wb_pc), .o_wb_insn(o_wb_insn),
      .o_wb_regfile_we(o_wb_regfile_we), .o_wb_wsel(o_wb_wsel), .o_wb_wdata(o_wb_wdata),
      .o_wb_nzp_we(o_wb_nzp_we), .o_wb_nzp(o_wb_nzp)
   );

endmodule

// ==== hw/lc4_decode_stage.sv ====
// LC4 decode stage
// Decodes, reads operands and holds the decode/execute pipeline register
module lc4_decode_stage (
   input  logic                          gwe,
   input  logic                          i_rst_n,
   input  logic [lc4_pkg::WORD_W-1:0]    i_fd_insn,
   input  logic [lc4_pkg::WORD_W-1:0]    i_fd_pc,
   input  logic                          i_fd_valid,
   input  logic                          i_flush,
   input  logic                          i_wb_regfile_we,
   input  logic [lc4_pkg::REG_SEL_W-1:0] i_wb_wsel,
   input  logic [lc4_pkg::WORD_W-1:0]    i_wb_wdata,
   output logic [lc4_pkg::WORD_W-1:0]    o_dx_insn,
   output logic [lc4_pkg::WORD_W-1:0]    o_dx_pc,
   output logic                          o_dx_valid,
   output logic [lc4_pkg::WORD_W-1:0]    o_dx_rs_data,
   output logic [lc4_pkg::WORD_W-1:0]    o_dx_rt_data,
   output logic [lc4_pkg::REG_SEL_W-1:0] o_dx_rs_sel,
   output logic [lc4_pkg::REG_SEL_W-1:0] o_dx_rt_sel,
   output logic [lc4_pkg::REG_SEL_W-1:0] o_dx_wsel,
   output logic                          o_dx_regfile_we,
   output logic                          o_dx_nzp_we,
   output logic                          o_dx_is_branch,
   output logic                          o_dx_is_jump,
   output lc4_pkg::alu_op_t              o_dx_alu_op
);

   logic [lc4_pkg::REG_SEL_W-1:0] rs_sel, rt_sel, wsel;
   logic                          regfile_we, nzp_we, is_branch, is_jump;
   logic [lc4_pkg::WORD_W-1:0]    rs_data, rt_data;
   lc4_pkg::alu_op_t              alu_op;
   logic                          keep;

   lc4_decoder u_decoder (
      .i_insn      (i_fd_insn),
      .o_rs_sel    (rs_sel),
      .o_rt_sel    (rt_sel),
      .o_wsel      (wsel),
      .o_regfile_we(regfile_we),
      .o_nzp_we    (nzp_we),
      .o_is_branch (is_branch),
      .o_is_jump   (is_jump),
      .o_alu_op    (alu_op)
   );

   lc4_regfile u_regfile (
      .gwe      (gwe),
      .i_rst_n  (i_rst_n),
      .i_rs     (rs_sel),
      .i_rt     (rt_sel),
      .i_rd     (i_wb_wsel),
      .i_wdata  (i_wb_wdata),
      .i_rd_we  (i_wb_regfile_we),
      .o_rs_data(rs_data),
      .o_rt_data(rt_data)
   );

   // Flushed or empty slot enters execute as a bubble
   assign keep = i_fd_valid && !i_flush;

   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_dx_valid      <= 1'b0;
         o_dx_regfile_we <= 1'b0;
         o_dx_nzp_we     <= 1'b0;
         o_dx_is_branch  <= 1'b0;
         o_dx_is_jump    <= 1'b0;
      end else begin
         o_dx_valid      <= keep;
         o_dx_regfile_we <= keep && regfile_we;
         o_dx_nzp_we     <= keep && nzp_we;
         o_dx_is_branch  <= keep && is_branch;
         o_dx_is_jump    <= keep && is_jump;
      end
   end

   always_ff @(posedge gwe) begin
      o_dx_insn    <= i_fd_insn;
      o_dx_pc      <= i_fd_pc;
      o_dx_rs_data <= rs_data;
      o_dx_rt_data <= rt_data;
      o_dx_rs_sel  <= rs_sel;
      o_dx_rt_sel  <= rt_sel;
      o_dx_wsel    <= wsel;
      o_dx_alu_op  <= alu_op;
   end

endmodule

// ==== hw/lc4_decoder.sv ====
// LC4 instruction decoder
// Register selects, write enables and ALU operation for the kept subset
module lc4_decoder (
   input  lc4_pkg::insn_t                i_insn,
   output logic [lc4_pkg::REG_SEL_W-1:0] o_rs_sel,
   output logic [lc4_pkg::REG_SEL_W-1:0] o_rt_sel,
   output logic [lc4_pkg::REG_SEL_W-1:0] o_wsel,
   output logic                          o_regfile_we,
   output logic                          o_nzp_we,
   output logic                          o_is_branch,
   output logic                          o_is_jump,
   output lc4_pkg::alu_op_t              o_alu_op
);

   logic writes;

   always_comb begin
      o_rs_sel    = i_insn.reg_form.rs;
      o_rt_sel    = i_insn.reg_form.rt;
      o_wsel      = i_insn.reg_form.rd;
      o_is_branch = 1'b0;
      o_is_jump   = 1'b0;
      o_alu_op    = lc4_pkg::ALU_PASS;
      writes      = 1'b0;
      case (i_insn.reg_form.opcode)
         lc4_pkg::OP_BR: begin
            o_is_branch = 1'b1;
            o_alu_op    = lc4_pkg::ALU_BR_TGT;
         end
         lc4_pkg::OP_ARITH: begin
            writes = 1'b1;
            if (i_insn.reg_form.subop[2]) begin
               o_alu_op = lc4_pkg::ALU_ADDI;
            end else begin
               case (i_insn.reg_form.subop)
                  lc4_pkg::SUB_ADD: o_alu_op = lc4_pkg::ALU_ADD;
                  lc4_pkg::SUB_MUL: o_alu_op = lc4_pkg::ALU_MUL;
                  lc4_pkg::SUB_SUB: o_alu_op = lc4_pkg::ALU_SUB;
                  // DIV is not kept
                  default:          writes   = 1'b0;
               endcase
            end
         end
         lc4_pkg::OP_LOGIC: begin
            writes = 1'b1;
            if (i_insn.reg_form.subop[2]) begin
               o_alu_op = lc4_pkg::ALU_ANDI;
            end else begin
               case (i_insn.reg_form.subop)
                  lc4_pkg::SUB_AND: o_alu_op = lc4_pkg::ALU_AND;
                  lc4_pkg::SUB_NOT: o_alu_op = lc4_pkg::ALU_NOT;
                  lc4_pkg::SUB_OR:  o_alu_op = lc4_pkg::ALU_OR;
                  default:          o_alu_op = lc4_pkg::ALU_XOR;
               endcase
            end
         end
         lc4_pkg::OP_CONST: begin
            writes   = 1'b1;
            o_alu_op = lc4_pkg::ALU_CONST;
         end
         lc4_pkg::OP_HICONST: begin
            // Low byte of rd is kept, so rd is read as rs
            writes   = 1'b1;
            o_rs_sel = i_insn.reg_form.rd;
            o_alu_op = lc4_pkg::ALU_HICONST;
         end
         lc4_pkg::OP_JMP: begin
            // Bit 11 clear is JMPR, not kept
            o_is_jump = i_insn.imm_form.rd_nzp[2];
            o_alu_op  = lc4_pkg::ALU_JMP_TGT;
         end
         default: ;
      endcase
      o_regfile_we = writes;
      o_nzp_we     = writes;
   end

endmodule

// ==== hw/lc4_execute.sv ====
// LC4 execute and writeback
// Bypass, ALU, NZP codes, branch resolution and the writeback trace register
module lc4_execute (
   input  logic                          gwe,
   input  logic                          i_rst_n,
   input  logic [lc4_pkg::WORD_W-1:0]    i_dx_insn,
   input  logic [lc4_pkg::WORD_W-1:0]    i_dx_pc,
   input  logic                          i_dx_valid,
   input  logic [lc4_pkg::WORD_W-1:0]    i_dx_rs_data,
   input  logic [lc4_pkg::WORD_W-1:0]    i_dx_rt_data,
   input  logic [lc4_pkg::REG_SEL_W-1:0] i_dx_rs_sel,
   input  logic [lc4_pkg::REG_SEL_W-1:0] i_dx_rt_sel,
   input  logic [lc4_pkg::REG_SEL_W-1:0] i_dx_wsel,
   input  logic                          i_dx_regfile_we,
   input  logic                          i_dx_nzp_we,
   input  logic                          i_dx_is_branch,
   input  logic                          i_dx_is_jump,
   input  lc4_pkg::alu_op_t              i_dx_alu_op,
   output logic                          o_redirect,
   output logic [lc4_pkg::WORD_W-1:0]    o_redirect_pc,
   output logic                          o_wb_valid,
   output logic [lc4_pkg::WORD_W-1:0]    o_wb_pc,
   output logic [lc4_pkg::WORD_W-1:0]    o_wb_insn,
   output logic                          o_wb_regfile_we,
   output logic [lc4_pkg::REG_SEL_W-1:0] o_wb_wsel,
   output logic [lc4_pkg::WORD_W-1:0]    o_wb_wdata,
   output logic                          o_wb_nzp_we,
   output logic [lc4_pkg::NZP_W-1:0]     o_wb_nzp
);

   lc4_pkg::insn_t                 insn;
   logic [lc4_pkg::WORD_W-1:0]     rs_val, rt_val, result;
   logic [lc4_pkg::NZP_W-1:0]      nzp_q, nzp_new;
   logic                           wb_hit;
   logic                           taken;

   assign insn   = i_dx_insn;
   assign wb_hit = o_wb_valid && o_wb_regfile_we;

   // Result still in writeback overrides the stale operand
   assign rs_val = (wb_hit && o_wb_wsel == i_dx_rs_sel) ? o_wb_wdata : i_dx_rs_data;
   assign rt_val = (wb_hit && o_wb_wsel == i_dx_rt_sel) ? o_wb_wdata : i_dx_rt_data;

   lc4_alu u_alu (
      .i_insn   (insn),
      .i_pc     (i_dx_pc),
      .i_alu_op (i_dx_alu_op),
      .i_rs_data(rs_val),
      .i_rt_data(rt_val),
      .o_result (result)
   );

   assign nzp_new = {result[15], result == '0, !result[15] && result != '0};

   assign taken         = i_dx_is_jump || (i_dx_is_branch && |(insn.imm_form.rd_nzp & nzp_q));
   assign o_redirect    = i_dx_valid && taken;
   assign o_redirect_pc = result;

   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         nzp_q           <= '0;
         o_wb_valid      <= 1'b0;
         o_wb_regfile_we <= 1'b0;
         o_wb_nzp_we     <= 1'b0;
      end else begin
         if (i_dx_valid && i_dx_nzp_we) begin
            nzp_q <= nzp_new;
         end
         // Bubbles from decode already carry cleared write enables
         o_wb_valid      <= i_dx_valid;
         o_wb_regfile_we <= i_dx_regfile_we;
         o_wb_nzp_we     <= i_dx_nzp_we;
      end
   end

   always_ff @(posedge gwe) begin
      o_wb_pc    <= i_dx_pc;
      o_wb_insn  <= i_dx_insn;
      o_wb_wsel  <= i_dx_wsel;
      o_wb_wdata <= result;
      o_wb_nzp   <= nzp_new;
   end

   a_we_valid: assert property (
      @(posedge gwe) disable iff (!i_rst_n)
      o_wb_regfile_we |-> o_wb_valid
   );
   a_nzp_onehot: assert property (
      @(posedge gwe) disable iff (!i_rst_n)
      o_wb_nzp_we |-> $onehot(o_wb_nzp)
   );

endmodule

// ==== hw/lc4_fetch.sv ====
// LC4 fetch stage
// Program counter with redirect, and the fetch/decode pipeline register
module lc4_fetch (
   input  logic                      gwe,
   input  logic                      i_rst_n,
   input  logic [lc4_pkg::WORD_W-1:0] i_cur_insn,
   input  logic                      i_redirect,
   input  logic [lc4_pkg::WORD_W-1:0] i_redirect_pc,
   output logic [lc4_pkg::WORD_W-1:0] o_cur_pc,
   output logic [lc4_pkg::WORD_W-1:0] o_fd_insn,
   output logic [lc4_pkg::WORD_W-1:0] o_fd_pc,
   output logic                      o_fd_valid
);

   logic [lc4_pkg::WORD_W-1:0] pc_q;
   logic [lc4_pkg::WORD_W-1:0] pc_next;

   // Sequential fetch unless execute resolved a taken transfer
   assign pc_next  = i_redirect ? i_redirect_pc : pc_q + 16'd1;
   assign o_cur_pc = pc_q;

   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         pc_q <= lc4_pkg::RESET_PC;
      end else begin
         pc_q <= pc_next;
      end
   end

   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_fd_valid <= 1'b0;
      end else begin
         // Wrong-path fetch becomes a bubble
         o_fd_valid <= !i_redirect;
      end
   end

   always_ff @(posedge gwe) begin
      o_fd_insn <= i_cur_insn;
      o_fd_pc   <= pc_q;
   end

   // Younger slot fetched alongside a taken transfer must never reach decode as valid
   a_redirect_squash: assert property (
      @(posedge gwe) disable iff (!i_rst_n)
      i_redirect |=> !o_fd_valid
   );

endmodule

// ==== hw/lc4_pkg.sv ====
// LC4 core shared definitions
// Widths, opcodes, sub-opcodes, ALU operation codes and the instruction word layout
package lc4_pkg;

   localparam int WORD_W    = 16;
   localparam int REG_SEL_W = 3;
   localparam int NZP_W     = 3;

   localparam logic [WORD_W-1:0] RESET_PC = 16'h8200;

   // Major opcodes in bits 15 to 12
   localparam logic [3:0] OP_BR      = 4'b0000;
   localparam logic [3:0] OP_ARITH   = 4'b0001;
   localparam logic [3:0] OP_LOGIC   = 4'b0101;
   localparam logic [3:0] OP_CONST   = 4'b1001;
   localparam logic [3:0] OP_HICONST = 4'b1101;
   localparam logic [3:0] OP_JMP     = 4'b1100;

   // Sub-opcodes in bits 5 to 3; bit 5 set selects the imm5 form
   localparam logic [2:0] SUB_ADD = 3'b000;
   localparam logic [2:0] SUB_MUL = 3'b001;
   localparam logic [2:0] SUB_SUB = 3'b010;
   localparam logic [2:0] SUB_AND = 3'b000;
   localparam logic [2:0] SUB_NOT = 3'b001;
   localparam logic [2:0] SUB_OR  = 3'b010;
   localparam logic [2:0] SUB_XOR = 3'b011;

   typedef enum logic [3:0] {
      ALU_ADD,
      ALU_MUL,
      ALU_SUB,
      ALU_AND,
      ALU_NOT,
      ALU_OR,
      ALU_XOR,
      ALU_ADDI,
      ALU_ANDI,
      ALU_CONST,
      ALU_HICONST,
      ALU_BR_TGT,
      ALU_JMP_TGT,
      ALU_PASS
   } alu_op_t;

   // Same 16 bits seen as a register form and as an immediate form
   typedef union packed {
      struct packed {
         logic [3:0]           opcode;
         logic [REG_SEL_W-1:0] rd;
         logic [REG_SEL_W-1:0] rs;
         logic [2:0]           subop;
         logic [REG_SEL_W-1:0] rt;
      } reg_form;
      struct packed {
         logic [3:0]           opcode;
         logic [REG_SEL_W-1:0] rd_nzp;
         logic [8:0]           imm9;
      } imm_form;
   } insn_t;

endpackage

// ==== hw/lc4_regfile.sv ====
// LC4 register file
// Eight 16-bit registers, two read ports, one write port with write-through
module lc4_regfile (
   input  logic                          gwe,
   input  logic                          i_rst_n,
   input  logic [lc4_pkg::REG_SEL_W-1:0] i_rs,
   input  logic [lc4_pkg::REG_SEL_W-1:0] i_rt,
   input  logic [lc4_pkg::REG_SEL_W-1:0] i_rd,
   input  logic [lc4_pkg::WORD_W-1:0]    i_wdata,
   input  logic                          i_rd_we,
   output logic [lc4_pkg::WORD_W-1:0]    o_rs_data,
   output logic [lc4_pkg::WORD_W-1:0]    o_rt_data
);

   logic [lc4_pkg::WORD_W-1:0] regs [0:7];

   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         for (int i = 0; i < 8; i++) begin
            regs[i] <= '0;
         end
      end else if (i_rd_we) begin
         regs[i_rd] <= i_wdata;
      end
   end

   // Same-cycle write is visible to the reader
   assign o_rs_data = (i_rd_we && i_rd == i_rs) ? i_wdata : regs[i_rs];
   assign o_rt_data = (i_rd_we && i_rd == i_rt) ? i_wdata : regs[i_rt];

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build the LC4 core testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module tb_lc4_core -o tb_lc4_core

status=0
./obj_dir/tb_lc4_core > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Simulation failed" sim.log; then
   echo "Run failed, see sim.log"
   exit 1
fi
if ! grep -q "Simulation passed" sim.log; then
   echo "Run ended without a result, see sim.log"
   exit 1
fi
echo "Run passed"

// ==== include/tb_lc4_ref.svh ====
// LC4 reference model
// One architectural step of the kept instruction subset, with its expected trace
`ifndef TB_LC4_REF_SVH
`define TB_LC4_REF_SVH

typedef struct packed {
   logic             regfile_we;
   logic [2:0]       wsel;
   logic [15:0]      wdata;
   logic             nzp_we;
   logic [2:0]       nzp;
   logic [15:0]      next_pc;
   logic [7:0][15:0] next_regs;
   logic [2:0]       next_nzp;
} step_t;

function automatic step_t ref_step(input logic [15:0] pc, input logic [7:0][15:0] regs,
                                   input logic [2:0] nzp, input logic [15:0] insn);
   step_t       s;
   logic [2:0]  rd;
   logic [15:0] a, b, imm5, imm9, imm11, value;
   logic        writes;
   rd        = insn[11:9];
   a         = regs[insn[8:6]];
   b         = regs[insn[2:0]];
   imm5      = {{11{insn[4]}}, insn[4:0]};
   imm9      = {{7{insn[8]}}, insn[8:0]};
   imm11     = {{5{insn[10]}}, insn[10:0]};
   value     = 16'h0000;
   writes    = 1'b1;
   s.next_pc = pc + 16'd1;
   case (insn[15:12])
      lc4_pkg::OP_BR: begin
         writes = 1'b0;
         if ((insn[11:9] & nzp) != 3'b000) begin
            s.next_pc = pc + 16'd1 + imm9;
         end
      end
      lc4_pkg::OP_ARITH: begin
         // Sub-opcodes 4 to 7 are the imm5 form
         case (insn[5:3])
            3'd0:    value = a + b;
            3'd1:    value = a * b;
            3'd2:    value = a - b;
            3'd3:    writes = 1'b0;
            default: value = a + imm5;
         endcase
      end
      lc4_pkg::OP_LOGIC: begin
         case (insn[5:3])
            3'd0:    value = a & b;
            3'd1:    value = ~a;
            3'd2:    value = a | b;
            3'd3:    value = a ^ b;
            default: value = a & imm5;
         endcase
      end
      lc4_pkg::OP_CONST:   value = imm9;
      lc4_pkg::OP_HICONST: value = {insn[7:0], regs[rd][7:0]};
      lc4_pkg::OP_JMP: begin
         // Bit 11 clear is JMPR, a no-op here
         writes = 1'b0;
         if (insn[11]) begin
            s.next_pc = pc + 16'd1 + imm11;
         end
      end
      default: writes = 1'b0;
   endcase
   s.regfile_we = writes;
   s.nzp_we     = writes;
   s.wsel       = rd;
   s.wdata      = value;
   s.nzp        = value[15] ? 3'b100 : ((value == 16'h0000) ? 3'b010 : 3'b001);
   s.next_regs  = regs;
   s.next_nzp   = writes ? s.nzp : nzp;
   if (writes) begin
      s.next_regs[rd] = value;
   end
   return s;
endfunction

`endif

// ==== verification/tb_lc4_core.sv ====
// Testbench for the LC4 pipelined core
// Directed prefix plus random program, checked at writeback against a reference model
module tb_lc4_core;

   `include "tb_lc4_ref.svh"

   localparam int          MEM_WORDS      = 256;
   localparam int          PREFIX_LEN     = 25;
   localparam int          NUM_RETIRE     = 400;
   localparam int          TIMEOUT_CYCLES = 3 * NUM_RETIRE + 20;
   localparam int          RESET_CYCLES   = 10;
   localparam logic [31:0] SEED           = 32'hbe493ec4;

   logic        gwe = 1'b0;
   logic        i_rst_n;
   logic [15:0] i_cur_insn;
   logic [15:0] o_cur_pc, o_wb_pc, o_wb_insn, o_wb_wdata;
   logic        o_wb_valid, o_wb_regfile_we, o_wb_nzp_we;
   logic [2:0]  o_wb_wsel, o_wb_nzp;

   logic [15:0]      imem [0:MEM_WORDS-1];
   logic [15:0]      model_pc = lc4_pkg::RESET_PC;
   logic [7:0][15:0] model_regs = '0;
   logic [2:0]       model_nzp = 3'b000;
   int               retired = 0;
   int               cycles = 0;
   int               checks = 0;
   int               mismatches = 0;
   int               timeouts = 0;
   bit               done = 1'b0;

   lc4_core UUT (.*);

   always #2 gwe = ~gwe;

   // Outside the loaded program the memory reads as NOP
   function automatic logic [15:0] fetch_word(input logic [15:0] addr);
      logic [15:0] off;
      off = addr - lc4_pkg::RESET_PC;
      if (off < 16'(MEM_WORDS)) begin
         return imem[off[7:0]];
      end
      return 16'h0000;
   endfunction

   always_comb begin
      i_cur_insn = fetch_word(o_cur_pc);
   end

   function automatic logic [15:0] enc_reg(input logic [3:0] op, input int rd, input int rs,
                                           input logic [2:0] sub, input int rt);
      return {op, rd[2:0], rs[2:0], sub, rt[2:0]};
   endfunction

   function automatic logic [15:0] enc_imm5(input logic [3:0] op, input int rd, input int rs,
                                            input int imm);
      return {op, rd[2:0], rs[2:0], 1'b1, imm[4:0]};
   endfunction

   function automatic logic [15:0] enc_imm9(input logic [3:0] op, input int rd_nzp, input int imm);
      return {op, rd_nzp[2:0], imm[8:0]};
   endfunction

   function automatic logic [15:0] enc_jmp(input int off);
      return {lc4_pkg::OP_JMP, 1'b1, off[10:0]};
   endfunction

   // Forward offsets only, so every target stays inside the program
   function automatic logic [15:0] random_insn(input int idx);
      int kind, rd, rs, rt, max_off;
      kind    = $urandom_range(0, 9);
      rd      = $urandom_range(0, 7);
      rs      = $urandom_range(0, 7);
      rt      = $urandom_range(0, 7);
      max_off = (MEM_WORDS - 2 - idx < 6) ? MEM_WORDS - 2 - idx : 6;
      case (kind)
         0, 1:    return enc_reg(lc4_pkg::OP_ARITH, rd, rs, 3'($urandom_range(0, 2)), rt);
         2:       return enc_imm5(lc4_pkg::OP_ARITH, rd, rs, $urandom_range(0, 31));
         3:       return enc_reg(lc4_pkg::OP_LOGIC, rd, rs, 3'($urandom_range(0, 3)), rt);
         4:       return enc_imm5(lc4_pkg::OP_LOGIC, rd, rs, $urandom_range(0, 31));
         5:       return enc_imm9(lc4_pkg::OP_CONST, rd, $urandom_range(0, 511));
         6:       return enc_imm9(lc4_pkg::OP_HICONST, rd, 256 + $urandom_range(0, 255));
         7, 8:    return enc_imm9(lc4_pkg::OP_BR, $urandom_range(0, 7), $urandom_range(0, max_off));
         default: return enc_jmp($urandom_range(0, max_off));
      endcase
   endfunction

   task automatic build_program();
      // Dependency chains at distances one, two and three
      imem[0]  = enc_imm9(lc4_pkg::OP_CONST, 1, 5);
      imem[1]  = enc_imm9(lc4_pkg::OP_CONST, 2, -3);
      imem[2]  = enc_reg(lc4_pkg::OP_ARITH, 3, 1, lc4_pkg::SUB_ADD, 2);
      imem[3]  = enc_reg(lc4_pkg::OP_ARITH, 4, 3, lc4_pkg::SUB_MUL, 1);
      imem[4]  = enc_reg(lc4_pkg::OP_ARITH, 5, 4, lc4_pkg::SUB_SUB, 3);
      imem[5]  = enc_imm9(lc4_pkg::OP_HICONST, 5, 256 + 'hA5);
      imem[6]  = enc_imm5(lc4_pkg::OP_ARITH, 6, 5, -1);
      imem[7]  = enc_reg(lc4_pkg::OP_LOGIC, 7, 6, lc4_pkg::SUB_XOR, 5);
      imem[8]  = enc_reg(lc4_pkg::OP_LOGIC, 1, 7, lc4_pkg::SUB_NOT, 0);
      imem[9]  = enc_reg(lc4_pkg::OP_LOGIC, 2, 1, lc4_pkg::SUB_OR, 7);
      imem[10] = enc_imm5(lc4_pkg::OP_LOGIC, 3, 2, 7);
      imem[11] = enc_reg(lc4_pkg::OP_LOGIC, 4, 3, lc4_pkg::SUB_AND, 3);
      // Taken BR, not-taken BR, taken BR, then a JMP, each over squashed words
      imem[12] = enc_imm9(lc4_pkg::OP_CONST, 0, 0);
      imem[13] = enc_imm9(lc4_pkg::OP_BR, 'b010, 2);
      imem[14] = enc_imm9(lc4_pkg::OP_CONST, 1, 1);
      imem[15] = enc_imm9(lc4_pkg::OP_CONST, 1, 2);
      imem[16] = enc_imm9(lc4_pkg::OP_BR, 'b100, 1);
      imem[17] = enc_imm9(lc4_pkg::OP_CONST, 1, -1);
      imem[18] = enc_imm9(lc4_pkg::OP_BR, 'b101, 1);
      imem[19] = enc_reg(lc4_pkg::OP_ARITH, 1, 1, lc4_pkg::SUB_ADD, 1);
      imem[20] = enc_jmp(2);
      imem[21] = enc_imm9(lc4_pkg::OP_CONST, 7, 1);
      imem[22] = enc_imm9(lc4_pkg::OP_CONST, 7, 2);
      imem[23] = enc_reg(lc4_pkg::OP_ARITH, 2, 1, lc4_pkg::SUB_ADD, 1);
      // DIV is outside the subset
      imem[24] = enc_reg(lc4_pkg::OP_ARITH, 3, 2, 3'b011, 1);
      for (int i = PREFIX_LEN; i < MEM_WORDS - 1; i++) begin
         imem[i] = random_insn(i);
      end
      imem[MEM_WORDS-1] = enc_jmp(-MEM_WORDS);
   endtask

   task automatic check_value(input string name, input logic [15:0] exp, input logic [15:0] act);
      checks++;
      if (exp !== act) begin
         mismatches++;
         $display("Fail %s at retirement %0d: expected %h, actual %h", name, retired, exp, act);
      end
   endtask

   task automatic finish_run();
      $display("Checks: %0d, mismatches: %0d, timeouts: %0d, retired: %0d",
               checks, mismatches, timeouts, retired);
      if (mismatches == 0 && timeouts == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   endtask

   always @(posedge gwe) begin : compare
      step_t       want;
      logic [15:0] want_insn;
      if (i_rst_n && !done) begin
         // First edge out of reset still shows the reset state
         if (cycles == 0) begin
            check_value("reset_cur_pc", lc4_pkg::RESET_PC, o_cur_pc);
            check_value("reset_wb_valid", 16'd0, 16'(o_wb_valid));
         end
         cycles++;
         if (o_wb_valid) begin
            want_insn = fetch_word(model_pc);
            want      = ref_step(model_pc, model_regs, model_nzp, want_insn);
            check_value("wb_pc", model_pc, o_wb_pc);
            check_value("wb_insn", want_insn, o_wb_insn);
            check_value("wb_regfile_we", 16'(want.regfile_we), 16'(o_wb_regfile_we));
            if (want.regfile_we) begin
               check_value("wb_wsel", 16'(want.wsel), 16'(o_wb_wsel));
               check_value("wb_wdata", want.wdata, o_wb_wdata);
            end
            check_value("wb_nzp_we", 16'(want.nzp_we), 16'(o_wb_nzp_we));
            if (want.nzp_we) begin
               check_value("wb_nzp", 16'(want.nzp), 16'(o_wb_nzp));
            end
            model_pc   = want.next_pc;
            model_regs = want.next_regs;
            model_nzp  = want.next_nzp;
            retired++;
         end
         if (retired == NUM_RETIRE) begin
            done = 1'b1;
            finish_run();
         end else if (cycles >= TIMEOUT_CYCLES) begin
            done = 1'b1;
            timeouts++;
            $display("Timeout after %0d cycles: the core stopped retiring instructions", cycles);
            finish_run();
         end
      end
   end

   initial begin
      void'($urandom(SEED));
      i_rst_n = 1'b0;
      build_program();
      repeat (RESET_CYCLES) @(posedge gwe);
      #1;
      i_rst_n = 1'b1;
   end

endmodule
